//--- hdl/sweep_pkg.sv
`default_nettype none

package sweep_pkg;

   //////////////////////////////
   // Settings bus
   //////////////////////////////
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      set_data_t data;
   } set_bus_t;

   // Register block bases
   localparam set_addr_t SR_MISC     = 8'd0;
   localparam set_addr_t SR_CHIRP    = 8'd8;
   localparam set_addr_t SR_SPI_CORE = 8'd20;

   //////////////////////////////
   // Wishbone and readback
   //////////////////////////////
   typedef logic [11:0] wb_adr_t;
   typedef logic [31:0] wb_dat_t;
   typedef logic [3:0]  rb_sel_t;

   localparam rb_sel_t RB_SPI     = 4'd0;
   localparam rb_sel_t RB_COMPAT  = 4'd12;
   localparam rb_sel_t RB_STATUS  = 4'd13;
   // Major in the upper half, minor in the lower half
   localparam wb_dat_t COMPAT_NUM = {16'd11, 16'd1};

   //////////////////////////////
   // SPI
   //////////////////////////////
   // Bit 0 upward: clk, dac, rx_dac, rx_adc, rx_db, tx_dac, tx_adc, tx_db, adc
   localparam int SPI_SLAVES = 9;
   typedef logic [SPI_SLAVES-1:0] spi_sen_t;
   localparam int SEN_RX_DB  = 4;
   localparam int SEN_TX_DAC = 5;

   typedef logic [5:0]  spi_len_t;
   typedef logic [15:0] spi_div_t;

   // Chirp sweep
   localparam spi_len_t CHIRP_WORD_LEN = 6'd32;
   typedef logic [15:0] chirp_cnt_t;
   typedef enum logic [1:0] {IDLE, LOAD, SHIFT, NEXT} chirp_state_t;

   // Receive settle before takeover
   localparam int RUN_SETTLE_CYCLES = 1000;
   typedef logic [$clog2(RUN_SETTLE_CYCLES+1)-1:0] settle_cnt_t;

   // Board LEDs, 1 selects the hardware source
   typedef logic [7:0] led_t;
   localparam led_t LED_SRC_RESET = 8'h1E;

endpackage

`default_nettype wire

//--- hdl/spi_shift_engine.sv
`timescale 1ns/1ps
`default_nettype none

module spi_shift_engine import sweep_pkg::*; (
   input  wire            dsp_clk,
   input  wire            dsp_rst,
   input  wire            start_i,
   input  wire spi_div_t  div_i,
   input  wire spi_len_t  len_i,
   input  wire set_data_t data_i,
   input  wire            miso_i,
   output logic           busy_o,
   output logic           sclk_o,
   output logic           mosi_o,
   output set_data_t      rdata_o
);

   logic      busy_r;
   logic      sclk_r;
   logic      half_done;
   spi_div_t  div_r;
   spi_div_t  half_cnt;
   spi_len_t  bits_left;
   set_data_t tx_sr;
   set_data_t rx_sr;

   // One half period of sclk is div cycles, a zero divider toggles every cycle
   assign half_done = (half_cnt + 16'd1 >= div_r);

   always_ff @(posedge dsp_clk) begin
      if (dsp_rst) begin
         busy_r    <= 1'b0;
         sclk_r    <= 1'b0;
         half_cnt  <= '0;
         bits_left <= '0;
      end else if (!busy_r) begin
         sclk_r   <= 1'b0;
         half_cnt <= '0;
         if (start_i && len_i != '0) begin
            busy_r    <= 1'b1;
            bits_left <= len_i;
         end
      end else if (half_done) begin
         half_cnt <= '0;
         sclk_r   <= ~sclk_r;
         // Falling edge closes a bit
         if (sclk_r) begin
            bits_left <= bits_left - 6'd1;
            if (bits_left == 6'd1)
               busy_r <= 1'b0;
         end
      end else begin
         half_cnt <= half_cnt + 16'd1;
      end
   end

   //////////////////////////////
   // Shift registers
   //////////////////////////////
   always_ff @(posedge dsp_clk) begin
      if (!busy_r && start_i) begin
         div_r <= div_i;
         tx_sr <= data_i;
         rx_sr <= '0;
      end else if (busy_r && half_done) begin
         if (sclk_r)
            tx_sr <= {tx_sr[30:0], 1'b0};
         else
            rx_sr <= {rx_sr[30:0], miso_i};
      end
   end

   assign busy_o  = busy_r;
   assign sclk_o  = sclk_r;
   assign mosi_o  = busy_r & tx_sr[31];
   assign rdata_o = rx_sr;

endmodule

`default_nettype wire

//--- hdl/wb_settings_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module wb_settings_bridge import sweep_pkg::*; (
   input  wire          dsp_clk,
   input  wire          dsp_rst,
   input  wire          wb_cyc_i,
   input  wire          wb_stb_i,
   input  wire          wb_we_i,
   input  wire wb_adr_t wb_adr_i,
   input  wire wb_dat_t wb_dat_i,
   output logic         wb_ack_o,
   output wb_dat_t      wb_dat_o,
   input  wire wb_dat_t spi_readback_i,
   input  wire [3:0]    status_i,
   output set_bus_t     set_o
);

   logic      ack_r;
   logic      req;
   logic      set_stb_r;
   set_addr_t set_addr_r;
   set_data_t set_data_r;
   wb_dat_t   rd_word;
   wb_dat_t   dat_r;

   // New request only while no ack is out
   assign req = wb_cyc_i && wb_stb_i && !ack_r;

   always_ff @(posedge dsp_clk) begin
      if (dsp_rst) begin
         ack_r     <= 1'b0;
         set_stb_r <= 1'b0;
      end else begin
         ack_r     <= req;
         set_stb_r <= req && wb_we_i;
      end
   end

   // Settings word and readback data
   always_ff @(posedge dsp_clk) begin
      if (req && wb_we_i) begin
         set_addr_r <= wb_adr_i[9:2];
         set_data_r <= wb_dat_i;
      end
      if (req && !wb_we_i)
         dat_r <= rd_word;
   end

   always_comb begin
      case (wb_adr_i[5:2])
         RB_SPI:    rd_word = spi_readback_i;
         RB_COMPAT: rd_word = COMPAT_NUM;
         RB_STATUS: rd_word = {28'd0, status_i};
         default:   rd_word = '1;
      endcase
   end

   assign wb_ack_o = ack_r;
   assign wb_dat_o = dat_r;
   assign set_o    = '{stb: set_stb_r, addr: set_addr_r, data: set_data_r};

endmodule

`default_nettype wire

//--- hdl/sys_spi_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module sys_spi_ctrl import sweep_pkg::*; (
   input  wire           dsp_clk,
   input  wire           dsp_rst,
   input  wire set_bus_t set_i,
   input  wire           miso_i,
   output spi_sen_t      sen_o,
   output logic          sclk_o,
   output logic          mosi_o,
   output logic          ready_o,
   output wb_dat_t       readback_o
);

   spi_div_t div_r;
   spi_sen_t mask_r;
   spi_len_t len_r;
   logic     busy;
   logic     start;

   // Data write kicks off a transfer, dropped while one is running
   assign start = set_i.stb && (set_i.addr == SR_SPI_CORE + 8'd2) && !busy;

   always_ff @(posedge dsp_clk) begin
      if (dsp_rst) begin
         div_r  <= '0;
         mask_r <= '0;
         len_r  <= '0;
      end else if (set_i.stb) begin
         if (set_i.addr == SR_SPI_CORE)
            div_r <= set_i.data[15:0];
         if (set_i.addr == SR_SPI_CORE + 8'd1) begin
            mask_r <= set_i.data[8:0];
            len_r  <= set_i.data[14:9];
         end
      end
   end

   spi_shift_engine spi_shift_engine_i (
      .dsp_clk(dsp_clk),
      .dsp_rst(dsp_rst),
      .start_i(start),
      .div_i(div_r),
      .len_i(len_r),
      .data_i(set_i.data),
      .miso_i(miso_i),
      .busy_o(busy),
      .sclk_o(sclk_o),
      .mosi_o(mosi_o),
      .rdata_o(readback_o)
   );

   // Selected slaves go low for the whole transfer
   assign sen_o   = busy ? ~mask_r : '1;
   assign ready_o = ~busy;

endmodule

`default_nettype wire

//--- hdl/chirp_sweep_seq.sv
`timescale 1ns/1ps
`default_nettype none

module chirp_sweep_seq import sweep_pkg::*; (
   input  wire           dsp_clk,
   input  wire           dsp_rst,
   input  wire set_bus_t set_i,
   input  wire           trigger_i,
   output logic          sen_rx_db_o,
   output logic          sen_tx_dac_o,
   output logic          sclk_o,
   output logic          mosi_o,
   output logic          busy_o,
   output logic          chirp_en_o
);

   set_data_t    start_r;
   set_data_t    step_r;
   set_data_t    word_r;
   chirp_cnt_t   count_r;
   chirp_cnt_t   left_r;
   spi_div_t     div_r;
   logic         tgt_rx_db_r;
   logic         tgt_tx_dac_r;
   logic         chirp_en_r;
   logic         trigger_d;
   logic         trig_rise;
   logic         eng_busy;
   chirp_state_t state;

   //////////////////////////////
   // Chirp settings
   //////////////////////////////
   always_ff @(posedge dsp_clk) begin
      if (dsp_rst) begin
         count_r      <= '0;
         tgt_rx_db_r  <= 1'b0;
         tgt_tx_dac_r <= 1'b0;
         chirp_en_r   <= 1'b0;
         div_r        <= '0;
      end else if (set_i.stb) begin
         if (set_i.addr == SR_CHIRP + 8'd2) begin
            count_r      <= set_i.data[15:0];
            tgt_rx_db_r  <= set_i.data[16];
            tgt_tx_dac_r <= set_i.data[17];
            chirp_en_r   <= set_i.data[31];
         end
         if (set_i.addr == SR_CHIRP + 8'd3)
            div_r <= set_i.data[15:0];
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (set_i.stb && set_i.addr == SR_CHIRP)
         start_r <= set_i.data;
      if (set_i.stb && set_i.addr == SR_CHIRP + 8'd1)
         step_r <= set_i.data;
   end

   //////////////////////////////
   // Sweep FSM
   //////////////////////////////
   assign trig_rise = trigger_i & ~trigger_d;

   always_ff @(posedge dsp_clk) begin
      if (dsp_rst) begin
         state     <= IDLE;
         trigger_d <= 1'b0;
      end else begin
         trigger_d <= trigger_i;
         case (state)
            IDLE:    if (trig_rise && chirp_en_r && count_r != '0) state <= LOAD;
            LOAD:    state <= SHIFT;
            // Engine is already busy on entry
            SHIFT:   if (!eng_busy) state <= NEXT;
            NEXT:    state <= (left_r == 16'd1) ? IDLE : LOAD;
            default: state <= IDLE;
         endcase
      end
   end

   // Word k is start plus k steps, wrapping at 32 bits
   always_ff @(posedge dsp_clk) begin
      if (state == IDLE) begin
         word_r <= start_r;
         left_r <= count_r;
      end else if (state == NEXT) begin
         word_r <= word_r + step_r;
         left_r <= left_r - 16'd1;
      end
   end

   spi_shift_engine spi_shift_engine_i (
      .dsp_clk(dsp_clk),
      .dsp_rst(dsp_rst),
      .start_i(state == LOAD),
      .div_i(div_r),
      .len_i(CHIRP_WORD_LEN),
      .data_i(word_r),
      .miso_i(1'b0),
      .busy_o(eng_busy),
      .sclk_o(sclk_o),
      .mosi_o(mosi_o),
      .rdata_o()
   );

   assign sen_rx_db_o  = ~(eng_busy & tgt_rx_db_r);
   assign sen_tx_dac_o = ~(eng_busy & tgt_tx_dac_r);
   assign busy_o       = (state != IDLE);
   assign chirp_en_o   = chirp_en_r;

endmodule

`default_nettype wire

//--- hdl/spi_takeover.sv
`timescale 1ns/1ps
`default_nettype none

module spi_takeover import sweep_pkg::*; (
   input  wire           dsp_clk,
   input  wire           dsp_rst,
   input  wire [1:0]     run_rx_i,
   input  wire           chirp_en_i,
   input  wire           chirp_busy_i,
   input  wire spi_sen_t sys_sen_i,
   input  wire           sys_sclk_i,
   input  wire           sys_mosi_i,
   input  wire           chirp_sen_rx_db_i,
   input  wire           chirp_sen_tx_dac_i,
   input  wire           chirp_sclk_i,
   input  wire           chirp_mosi_i,
   output spi_sen_t      sen_o,
   output logic          sclk_o,
   output logic          mosi_o,
   output logic          rx_running_o,
   output logic          trigger_o,
   output logic          vco_init_done_o
);

   logic        run_d;
   logic        trigger;
   logic        vco_init_done_r;
   settle_cnt_t settle_cnt;

   // Receive must run steadily before the sweep may start
   always_ff @(posedge dsp_clk) begin
      if (dsp_rst) begin
         run_d           <= 1'b0;
         settle_cnt      <= '0;
         vco_init_done_r <= 1'b0;
      end else begin
         run_d <= |run_rx_i;
         if (!run_d)
            settle_cnt <= '0;
         else if (settle_cnt != settle_cnt_t'(RUN_SETTLE_CYCLES))
            settle_cnt <= settle_cnt + 1'b1;
         if (trigger)
            vco_init_done_r <= 1'b1;
      end
   end

   assign trigger = run_d && (settle_cnt == settle_cnt_t'(RUN_SETTLE_CYCLES));

   //////////////////////////////
   // Pin ownership
   //////////////////////////////
   always_comb begin
      sen_o = sys_sen_i;
      if (vco_init_done_r && chirp_en_i) begin
         sen_o[SEN_RX_DB]  = chirp_sen_rx_db_i;
         sen_o[SEN_TX_DAC] = chirp_sen_tx_dac_i;
      end
   end

   assign sclk_o = (trigger && chirp_en_i && chirp_busy_i) ? chirp_sclk_i : sys_sclk_i;
   assign mosi_o = (trigger && chirp_en_i && chirp_busy_i) ? chirp_mosi_i : sys_mosi_i;

   assign rx_running_o    = run_d;
   assign trigger_o       = trigger;
   assign vco_init_done_o = vco_init_done_r;

endmodule

`default_nettype wire

//--- hdl/board_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module board_ctrl_regs import sweep_pkg::*; (
   input  wire           dsp_clk,
   input  wire           dsp_rst,
   input  wire set_bus_t set_i,
   input  wire           rx_running_i,
   input  wire           run_tx_i,
   input  wire           clk_status_i,
   input  wire           link_good_i,
   output led_t          leds_o,
   output logic [3:0]    serdes_ctrl_o,
   output logic [3:0]    adc_ctrl_o
);

   led_t led_sw_r;
   led_t led_src_r;
   led_t led_hw;

   always_ff @(posedge dsp_clk) begin
      if (dsp_rst) begin
         serdes_ctrl_o <= '0;
         adc_ctrl_o    <= '0;
         led_sw_r      <= '0;
         led_src_r     <= LED_SRC_RESET;
      end else if (set_i.stb) begin
         case (set_i.addr)
            SR_MISC + 8'd1: serdes_ctrl_o <= set_i.data[3:0];
            SR_MISC + 8'd2: adc_ctrl_o    <= set_i.data[3:0];
            SR_MISC + 8'd3: led_sw_r      <= set_i.data[7:0];
            SR_MISC + 8'd6: led_src_r     <= set_i.data[7:0];
            default: ;
         endcase
      end
   end

   //////////////////////////////
   // LED source mux
   //////////////////////////////
   // Status flags on bits 4..1
   assign led_hw = {3'b000, run_tx_i, rx_running_i, clk_status_i, link_good_i, 1'b0};

   assign leds_o = (led_src_r & led_hw) | (~led_src_r & led_sw_r);

endmodule

`default_nettype wire

//--- hdl/sweep_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module sweep_core_top import sweep_pkg::*; (
   input  wire          dsp_clk,
   input  wire          dsp_rst,
   input  wire          wb_cyc_i,
   input  wire          wb_stb_i,
   input  wire          wb_we_i,
   input  wire wb_adr_t wb_adr_i,
   input  wire wb_dat_t wb_dat_i,
   input  wire [1:0]    run_rx_i,
   input  wire          run_tx_i,
   input  wire          clk_status_i,
   input  wire          link_good_i,
   input  wire          miso_i,
   output logic         wb_ack_o,
   output wb_dat_t      wb_dat_o,
   output spi_sen_t     sen_o,
   output logic         sclk_o,
   output logic         mosi_o,
   output led_t         leds_o,
   output logic [3:0]   serdes_ctrl_o,
   output logic [3:0]   adc_ctrl_o
);

   set_bus_t set_bus;
   wb_dat_t  spi_readback;
   logic     spi_ready;
   spi_sen_t sys_sen;
   logic     sys_sclk;
   logic     sys_mosi;
   logic     chirp_sen_rx_db;
   logic     chirp_sen_tx_dac;
   logic     chirp_sclk;
   logic     chirp_mosi;
   logic     chirp_busy;
   logic     chirp_en;
   logic     rx_running;
   logic     trigger;
   logic     vco_init_done;

   wb_settings_bridge wb_settings_bridge_i (
      .dsp_clk(dsp_clk), .dsp_rst(dsp_rst),
      .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
      .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
      .wb_ack_o(wb_ack_o), .wb_dat_o(wb_dat_o),
      .spi_readback_i(spi_readback),
      .status_i({chirp_busy, vco_init_done, trigger, spi_ready}),
      .set_o(set_bus));

   sys_spi_ctrl sys_spi_ctrl_i (
      .dsp_clk(dsp_clk), .dsp_rst(dsp_rst), .set_i(set_bus), .miso_i(miso_i),
      .sen_o(sys_sen), .sclk_o(sys_sclk), .mosi_o(sys_mosi),
      .ready_o(spi_ready), .readback_o(spi_readback));

   chirp_sweep_seq chirp_sweep_seq_i (
      .dsp_clk(dsp_clk), .dsp_rst(dsp_rst), .set_i(set_bus), .trigger_i(trigger),
      .sen_rx_db_o(chirp_sen_rx_db), .sen_tx_dac_o(chirp_sen_tx_dac),
      .sclk_o(chirp_sclk), .mosi_o(chirp_mosi),
      .busy_o(chirp_busy), .chirp_en_o(chirp_en));

   spi_takeover spi_takeover_i (
      .dsp_clk(dsp_clk), .dsp_rst(dsp_rst), .run_rx_i(run_rx_i),
      .chirp_en_i(chirp_en), .chirp_busy_i(chirp_busy),
      .sys_sen_i(sys_sen), .sys_sclk_i(sys_sclk), .sys_mosi_i(sys_mosi),
      .chirp_sen_rx_db_i(chirp_sen_rx_db), .chirp_sen_tx_dac_i(chirp_sen_tx_dac),
      .chirp_sclk_i(chirp_sclk), .chirp_mosi_i(chirp_mosi),
      .sen_o(sen_o), .sclk_o(sclk_o), .mosi_o(mosi_o),
      .rx_running_o(rx_running), .trigger_o(trigger), .vco_init_done_o(vco_init_done));

   board_ctrl_regs board_ctrl_regs_i (
      .dsp_clk(dsp_clk), .dsp_rst(dsp_rst), .set_i(set_bus),
      .rx_running_i(rx_running), .run_tx_i(run_tx_i),
      .clk_status_i(clk_status_i), .link_good_i(link_good_i),
      .leds_o(leds_o), .serdes_ctrl_o(serdes_ctrl_o), .adc_ctrl_o(adc_ctrl_o));

endmodule

`default_nettype wire

//--- verif/sweep_core_sva.sv
`timescale 1ns/1ps
`default_nettype none

module sweep_core_sva import sweep_pkg::*; (
   input wire           dsp_clk,
   input wire           dsp_rst,
   input wire           wb_cyc_i,
   input wire           wb_stb_i,
   input wire           wb_ack_i,
   input wire spi_sen_t sen_i,
   input wire           sclk_i
);

   // Ack is a one-cycle pulse
   ack_single_cycle: assert property (@(posedge dsp_clk) disable iff (dsp_rst)
      wb_ack_i |=> !wb_ack_i)
      else $error("wb ack held for more than one cycle");

   ack_inside_cycle: assert property (@(posedge dsp_clk) disable iff (dsp_rst)
      wb_ack_i |-> (wb_cyc_i && wb_stb_i))
      else $error("wb ack outside a bus cycle");

   // No clock on the pins while every slave is deselected
   sclk_idle_deselected: assert property (@(posedge dsp_clk) disable iff (dsp_rst)
      (&sen_i) |-> !sclk_i)
      else $error("sclk active with all chip selects high");

endmodule

bind wb_settings_bridge sweep_core_sva bridge_sva_i (
   .dsp_clk(dsp_clk), .dsp_rst(dsp_rst),
   .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_ack_i(wb_ack_o),
   // Bridge has no SPI pins
   .sen_i('1), .sclk_i(1'b0));

bind spi_takeover sweep_core_sva takeover_sva_i (
   .dsp_clk(dsp_clk), .dsp_rst(dsp_rst),
   .wb_cyc_i(1'b0), .wb_stb_i(1'b0), .wb_ack_i(1'b0),
   .sen_i(sen_o), .sclk_i(sclk_o));

`default_nettype wire

//--- verif/sweep_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sweep_core_tb import sweep_pkg::*; ();

   logic       dsp_clk;
   logic       dsp_rst;
   logic       wb_cyc;
   logic       wb_stb;
   logic       wb_we;
   wb_adr_t    wb_adr;
   wb_dat_t    wb_dat_w;
   logic [1:0] run_rx;
   logic       run_tx;
   logic       clk_status;
   logic       link_good;
   logic       miso;
   logic       wb_ack;
   wb_dat_t    wb_dat_r;
   spi_sen_t   sen;
   logic       sclk;
   logic       mosi;
   led_t       leds;
   logic [3:0] serdes_ctrl;
   logic [3:0] adc_ctrl;

   sweep_core_top sweep_core_top_i (
      .dsp_clk(dsp_clk), .dsp_rst(dsp_rst),
      .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
      .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w),
      .run_rx_i(run_rx), .run_tx_i(run_tx), .clk_status_i(clk_status),
      .link_good_i(link_good), .miso_i(miso),
      .wb_ack_o(wb_ack), .wb_dat_o(wb_dat_r), .sen_o(sen), .sclk_o(sclk), .mosi_o(mosi),
      .leds_o(leds), .serdes_ctrl_o(serdes_ctrl), .adc_ctrl_o(adc_ctrl));

   initial begin
      dsp_clk = 1'b0;
      forever #2 dsp_clk = ~dsp_clk;
   end

   //////////////////////////////
   // Checks
   //////////////////////////////
   task automatic stop_with(input string msg);
      $display("%s", msg);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at %0t ns", $time);
   endtask

   task automatic check_dat(input string name, input wb_dat_t got, input wb_dat_t exp);
      if (got !== exp)
         stop_with($sformatf("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp));
   endtask

   task automatic check_sen(input string name, input spi_sen_t got, input spi_sen_t exp);
      if (got !== exp)
         stop_with($sformatf("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp));
   endtask

   task automatic check_leds(input led_t got, input led_t exp);
      if (got !== exp)
         stop_with($sformatf("** Error at %0t ns: leds_o = %h, expected %h", $time, got, exp));
   endtask

   task automatic check_ctrl(input string name, input logic [3:0] got, input logic [3:0] exp);
      if (got !== exp)
         stop_with($sformatf("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp));
   endtask

   // Hardware word holds the status flags on bits 4..1
   function automatic led_t led_expect(input led_t src, input led_t sw);
      led_t hw;
      led_t res;
      hw = '0;
      hw[4] = run_tx;
      hw[3] = (run_rx != 2'b00);
      hw[2] = clk_status;
      hw[1] = link_good;
      for (int i = 0; i < 8; i++)
         res[i] = src[i] ? hw[i] : sw[i];
      return res;
   endfunction

   //////////////////////////////
   // Bus and SPI tasks
   //////////////////////////////
   task automatic wb_cycle(input logic we, input wb_adr_t adr, input wb_dat_t wdat,
                           output wb_dat_t rdat);
      int n;
      n = 0;
      @(posedge dsp_clk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= adr;
      wb_dat_w <= wdat;
      do begin
         @(negedge dsp_clk);
         n++;
         if (n > 16)
            stop_with("Wishbone slave gave no ack within 16 cycles");
      end while (wb_ack !== 1'b1);
      rdat = wb_dat_r;
      @(posedge dsp_clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic wb_write(input set_addr_t addr, input set_data_t data);
      wb_dat_t unused;
      wb_cycle(1'b1, {2'b00, addr, 2'b00}, data, unused);
   endtask

   task automatic wb_read(input logic [3:0] word, output wb_dat_t data);
      wb_cycle(1'b0, {6'd0, word, 2'b00}, '0, data);
   endtask

   task automatic wait_status(input int idx, input logic val);
      wb_dat_t st;
      int n;
      n = 0;
      do begin
         wb_read(4'd13, st);
         n++;
         if (n > 500)
            stop_with($sformatf("Status bit %0d never reached %0b", idx, val));
      end while (st[idx] !== val);
   endtask

   // Mosi taken on each rising sclk of a fresh select
   task automatic spi_capture(input int sel, input int nbits, output set_data_t word,
                              output spi_sen_t sen_seen);
      int n;
      int got;
      logic sclk_prev;
      n = 0;
      got = 0;
      word = '0;
      do begin
         @(negedge dsp_clk);
         n++;
         if (n > 3000)
            stop_with($sformatf("Chip select %0d stayed low", sel));
      end while (sen[sel] !== 1'b1);
      n = 0;
      do begin
         @(negedge dsp_clk);
         n++;
         if (n > 3000)
            stop_with($sformatf("Chip select %0d never went low", sel));
      end while (sen[sel] !== 1'b0);
      sen_seen = sen;
      sclk_prev = sclk;
      n = 0;
      while (got < nbits) begin
         @(negedge dsp_clk);
         n++;
         if (n > 4000)
            stop_with("SPI transfer did not deliver all bits in time");
         if (sen[sel] !== 1'b0)
            stop_with($sformatf("Chip select %0d rose after %0d bits", sel, got));
         if (sclk === 1'b1 && sclk_prev === 1'b0) begin
            word = {word[30:0], mosi};
            got++;
         end
         sclk_prev = sclk;
      end
   endtask

   //////////////////////////////
   // Directed tests
   //////////////////////////////
   task automatic test_readback();
      wb_dat_t d;
      wb_read(4'd12, d);
      check_dat("wb_dat_o word 12", d, 32'h000B_0001);
      wb_read(4'd5, d);
      check_dat("wb_dat_o word 5", d, 32'hFFFF_FFFF);
      wb_read(4'd13, d);
      check_dat("wb_dat_o status", d, 32'h0000_0001);
   endtask

   task automatic test_board_regs();
      @(negedge dsp_clk);
      check_leds(leds, led_expect(8'h1E, 8'h00));
      wb_write(SR_MISC + 8'd6, 32'h0);
      wb_write(SR_MISC + 8'd3, 32'hA5);
      @(negedge dsp_clk);
      check_leds(leds, 8'hA5);
      // Mixed sources
      wb_write(SR_MISC + 8'd6, 32'h12);
      @(negedge dsp_clk);
      check_leds(leds, led_expect(8'h12, 8'hA5));
      // Registered receive flag on bit 3
      wb_write(SR_MISC + 8'd6, 32'h1E);
      run_rx <= 2'b01;
      @(posedge dsp_clk);
      @(negedge dsp_clk);
      check_leds(leds, led_expect(8'h1E, 8'hA5));
      @(posedge dsp_clk);
      run_rx <= 2'b00;
      wb_write(SR_MISC + 8'd1, 32'h3C);
      wb_write(SR_MISC + 8'd2, 32'h5A);
      @(negedge dsp_clk);
      check_ctrl("serdes_ctrl_o", serdes_ctrl, 4'hC);
      check_ctrl("adc_ctrl_o", adc_ctrl, 4'hA);
   endtask

   task automatic test_sys_spi();
      set_data_t data;
      set_data_t word;
      spi_sen_t  seen;
      wb_dat_t   d;
      data = $urandom;
      // Mask of rx_adc and length 24
      wb_write(SR_SPI_CORE + 8'd1, {17'd0, 6'd24, 9'b0_0000_1000});
      wb_write(SR_SPI_CORE, 32'd2);
      fork
         spi_capture(3, 24, word, seen);
         wb_write(SR_SPI_CORE + 8'd2, data);
      join
      check_sen("sen_o", seen, 9'b1_1111_0111);
      check_dat("mosi_o word", word, {8'd0, data[31:8]});
      wait_status(0, 1'b1);
      wb_read(4'd0, d);
      check_dat("wb_dat_o SPI readback", d, 32'h00FF_FFFF);
   endtask

   task automatic test_settle();
      wb_dat_t d;
      @(posedge dsp_clk);
      run_rx <= 2'b01;
      repeat (500) @(posedge dsp_clk);
      run_rx <= 2'b00;
      wb_read(4'd13, d);
      check_dat("wb_dat_o status", d, 32'h1);
      @(posedge dsp_clk);
      run_rx <= 2'b10;
      repeat (1100) @(posedge dsp_clk);
      wb_read(4'd13, d);
      check_dat("wb_dat_o status", d, 32'h7);
      @(posedge dsp_clk);
      run_rx <= 2'b00;
      wb_read(4'd13, d);
      check_dat("wb_dat_o status", d, 32'h5);
   endtask

   task automatic test_chirp_takeover();
      set_data_t start_w;
      set_data_t step_w;
      set_data_t exp;
      set_data_t word;
      spi_sen_t  seen;
      wb_dat_t   d;
      start_w = $urandom;
      step_w = $urandom;
      exp = start_w;
      wb_write(SR_CHIRP, start_w);
      wb_write(SR_CHIRP + 8'd1, step_w);
      wb_write(SR_CHIRP + 8'd3, 32'd2);
      // Enabled sweep of three words to rx_db
      wb_write(SR_CHIRP + 8'd2, 32'h8001_0003);
      fork
         begin
            @(posedge dsp_clk);
            run_rx <= 2'b01;
         end
         for (int k = 0; k < 3; k++) begin
            spi_capture(4, 32, word, seen);
            check_sen("sen_o", seen, 9'b1_1110_1111);
            check_dat($sformatf("mosi_o chirp word %0d", k), word, exp);
            exp = exp + step_w;
         end
      join
      wait_status(3, 1'b0);
      // Only rx_adc may drop on a system write to both selects
      wb_write(SR_SPI_CORE + 8'd1, {17'd0, 6'd8, 9'b0_0001_1000});
      wb_write(SR_SPI_CORE, 32'd4);
      wb_write(SR_SPI_CORE + 8'd2, $urandom);
      @(negedge dsp_clk);
      check_sen("sen_o", sen, 9'b1_1111_0111);
      wb_read(4'd13, d);
      check_dat("wb_dat_o status", d, 32'h6);
      wait_status(0, 1'b1);
   endtask

   initial begin
      void'($urandom(8514));
      dsp_rst    = 1'b1;
      wb_cyc     = 1'b0;
      wb_stb     = 1'b0;
      wb_we      = 1'b0;
      wb_adr     = '0;
      wb_dat_w   = '0;
      run_rx     = 2'b00;
      run_tx     = 1'b1;
      clk_status = 1'b1;
      link_good  = 1'b1;
      miso       = 1'b1;
      repeat (8) @(posedge dsp_clk);
      dsp_rst <= 1'b0;
      test_readback();
      test_board_regs();
      test_sys_spi();
      test_settle();
      test_chirp_takeover();
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
hdl/sweep_pkg.sv
hdl/spi_shift_engine.sv
hdl/wb_settings_bridge.sv
hdl/sys_spi_ctrl.sv
hdl/chirp_sweep_seq.sv
hdl/spi_takeover.sv
hdl/board_ctrl_regs.sv
hdl/sweep_core_top.sv
verif/sweep_core_sva.sv
verif/sweep_core_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := sweep_core_tb
FILELIST   := src.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing -Wall --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
